// File: cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

`default_nettype none

// datapath word and register width
`define DATA_W 16
// register index width, sixteen registers
`define REG_AW 4

// memory word-index widths, 256 words each
`define IMEM_AW 8
`define DMEM_AW 8

// fetch address out of reset
`define RESET_PC 16'h0000

// bit positions inside the 3-bit flag vector
`define FLAG_Z 2
`define FLAG_V 1
`define FLAG_N 0

`default_nettype wire

`endif

// File: isa_pkg.sv
`include "cpu_defs.svh"
`default_nettype none

package isa_pkg;

	// major opcode in instruction bits 15:12
	typedef enum logic [3:0] {
		ADD = 4'd0,
		SUB = 4'd1,
		XOR = 4'd2,
		AND = 4'd3,
		// shifts take the unsigned immediate as amount
		SLL = 4'd4,
		SRA = 4'd5,
		ROR = 4'd6,
		OR  = 4'd7,
		LW  = 4'd8,
		SW  = 4'd9,
		LLB = 4'd10,
		LHB = 4'd11,
		B   = 4'd12,
		// register-indirect branch slot, retires as a no-op
		NOP = 4'd13,
		PCS = 4'd14,
		HLT = 4'd15
	} opcode_t;

	// branch condition in bits 11:9, tested against Z/V/N
	typedef enum logic [2:0] {
		NE  = 3'd0,
		EQ  = 3'd1,
		GT  = 3'd2,
		LT  = 3'd3,
		GE  = 3'd4,
		LE  = 3'd5,
		OV  = 3'd6,
		UNC = 3'd7
	} cond_t;

	// register-format view of an instruction word
	typedef struct packed {
		opcode_t              opcode;
		logic [`REG_AW-1:0]   rd;
		logic [`REG_AW-1:0]   rs;
		logic [`REG_AW-1:0]   rt;
	} instr_t;

endpackage

`default_nettype wire

// File: core_pkg.sv
`default_nettype none

package core_pkg;

	// operation performed by the ALU
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_XOR,
		ALU_AND,
		ALU_OR,
		ALU_SLL,
		ALU_SRA,
		ALU_ROR
	} alu_op_t;

	// source of the register-file write data
	typedef enum logic [1:0] {
		// ALU result
		WB_ALU,
		// data memory load
		WB_MEM,
		// LLB / LHB byte merge
		WB_BYTE,
		// return address, PC+2
		WB_PCS
	} wb_src_t;

endpackage

`default_nettype wire

// File: pc_unit.sv
`include "cpu_defs.svh"
`timescale 1ns/10ps
`default_nettype none

module pc_unit (
	input  logic                clk,
	input  logic                reset,
	input  logic                branch,
	input  isa_pkg::cond_t      cond,
	input  logic [8:0]          offset,
	input  logic [2:0]          flags,
	input  logic                halt_req,
	output logic [`DATA_W-1:0]  pc,
	output logic [`DATA_W-1:0]  pc_plus2,
	output logic                halted
);
	import isa_pkg::*;

	logic               z;
	logic               v;
	logic               n;
	logic               taken;
	logic [`DATA_W-1:0] target;
	logic [`DATA_W-1:0] next_pc;

	assign z = flags[`FLAG_Z];
	assign v = flags[`FLAG_V];
	assign n = flags[`FLAG_N];

	// condition test against the stored flags
	always_comb begin
		case (cond)
			NE:      taken = ~z;
			EQ:      taken = z;
			GT:      taken = ~z & ~n;
			LT:      taken = n;
			GE:      taken = ~n;
			LE:      taken = z | n;
			OV:      taken = v;
			UNC:     taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	// byte addressing, one instruction is two bytes
	assign pc_plus2 = pc + `DATA_W'(2);

	// word offset, sign extended and doubled
	assign target = pc_plus2 + {{(`DATA_W-10){offset[8]}}, offset, 1'b0};

	assign next_pc = (branch && taken) ? target : pc_plus2;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc     <= `RESET_PC;
			halted <= 1'b0;
		end else if (!halted) begin
			// pc stays on the HLT word from here on
			if (halt_req) begin
				halted <= 1'b1;
			end else begin
				pc <= next_pc;
			end
		end
	end

endmodule

`default_nettype wire

// File: control_unit.sv
`include "cpu_defs.svh"
`timescale 1ns/10ps
`default_nettype none

module control_unit (
	input  logic              reset,
	input  logic              halted,
	input  isa_pkg::opcode_t  opcode,
	output core_pkg::alu_op_t alu_op,
	output logic              alu_imm,
	output logic              src1_is_dst,
	output logic              reg_write,
	output logic              mem_write,
	output logic [2:0]        flag_write_en,
	output core_pkg::wb_src_t wb_src,
	output logic              branch,
	output logic              halt_req
);
	import isa_pkg::*;
	import core_pkg::*;

	logic       active;
	logic       reg_write_raw;
	logic       mem_write_raw;
	logic [2:0] flag_raw;
	logic       branch_raw;
	logic       halt_raw;

	// no state may change in reset or after HLT
	assign active = ~reset & ~halted;

	always_comb begin
		alu_op        = ALU_ADD;
		alu_imm       = 1'b0;
		src1_is_dst   = 1'b0;
		wb_src        = WB_ALU;
		reg_write_raw = 1'b0;
		mem_write_raw = 1'b0;
		flag_raw      = 3'b000;
		branch_raw    = 1'b0;
		halt_raw      = 1'b0;
		case (opcode)
			// arithmetic updates all three flags
			ADD: begin
				reg_write_raw = 1'b1;
				flag_raw      = 3'b111;
			end
			SUB: begin
				alu_op        = ALU_SUB;
				reg_write_raw = 1'b1;
				flag_raw      = 3'b111;
			end
			// logic ops and shifts touch Z only
			XOR, AND, OR: begin
				alu_op                = (opcode == XOR) ? ALU_XOR :
				                        (opcode == AND) ? ALU_AND : ALU_OR;
				reg_write_raw         = 1'b1;
				flag_raw[`FLAG_Z]     = 1'b1;
			end
			SLL, SRA, ROR: begin
				alu_op                = (opcode == SLL) ? ALU_SLL :
				                        (opcode == SRA) ? ALU_SRA : ALU_ROR;
				alu_imm               = 1'b1;
				reg_write_raw         = 1'b1;
				flag_raw[`FLAG_Z]     = 1'b1;
			end
			LW: begin
				wb_src        = WB_MEM;
				reg_write_raw = 1'b1;
			end
			SW:  mem_write_raw = 1'b1;
			// byte loads merge into the old destination value
			LLB, LHB: begin
				src1_is_dst   = 1'b1;
				wb_src        = WB_BYTE;
				reg_write_raw = 1'b1;
			end
			B:   branch_raw = 1'b1;
			PCS: begin
				wb_src        = WB_PCS;
				reg_write_raw = 1'b1;
			end
			HLT: halt_raw = 1'b1;
			default: ;
		endcase
	end

	assign reg_write     = reg_write_raw & active;
	assign mem_write     = mem_write_raw & active;
	assign flag_write_en = flag_raw & {3{active}};
	assign branch        = branch_raw & active;
	assign halt_req      = halt_raw & active;

endmodule

`default_nettype wire

// File: register_file.sv
`include "cpu_defs.svh"
`timescale 1ns/10ps
`default_nettype none

module register_file (
	input  logic                clk,
	input  logic                reset,
	input  logic [`REG_AW-1:0]  src1,
	input  logic [`REG_AW-1:0]  src2,
	input  logic [`REG_AW-1:0]  dst,
	input  logic                write_en,
	input  logic [`DATA_W-1:0]  write_data,
	output logic [`DATA_W-1:0]  src1_data,
	output logic [`DATA_W-1:0]  src2_data
);

	localparam int NUM_REGS = 1 << `REG_AW;

	logic [`DATA_W-1:0] regs [0:NUM_REGS-1];

	// all registers read as zero after reset
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en) begin
			regs[dst] <= write_data;
		end
	end

	// no bypass, a same-cycle read sees the old value
	assign src1_data = regs[src1];
	assign src2_data = regs[src2];

endmodule

`default_nettype wire

// File: alu.sv
`include "cpu_defs.svh"
`timescale 1ns/10ps
`default_nettype none

module alu (
	input  logic                clk,
	input  logic                reset,
	input  core_pkg::alu_op_t   op,
	input  logic [`DATA_W-1:0]  a,
	input  logic [`DATA_W-1:0]  b,
	input  logic [2:0]          flag_write_en,
	output logic [`DATA_W-1:0]  result,
	output logic [2:0]          flags
);
	import core_pkg::*;

	logic [`DATA_W-1:0]   sum;
	logic [`DATA_W-1:0]   diff;
	logic                 add_ovf;
	logic                 sub_ovf;
	logic [`DATA_W-1:0]   max_pos;
	logic [`DATA_W-1:0]   max_neg;
	logic [3:0]           shamt;
	logic [2*`DATA_W-1:0] rot;
	logic                 ovf;

	// saturation limits, 0x7FFF and 0x8000
	assign max_pos = {1'b0, {(`DATA_W-1){1'b1}}};
	assign max_neg = {1'b1, {(`DATA_W-1){1'b0}}};

	assign sum  = a + b;
	assign diff = a - b;

	// signed overflow from the operand and result signs
	assign add_ovf = (a[`DATA_W-1] == b[`DATA_W-1]) && (sum[`DATA_W-1] != a[`DATA_W-1]);
	assign sub_ovf = (a[`DATA_W-1] != b[`DATA_W-1]) && (diff[`DATA_W-1] != a[`DATA_W-1]);

	// shift amount is always the low nibble of b
	assign shamt = b[3:0];

	// doubled word shifted right gives the rotation in the low half
	assign rot = {a, a} >> shamt;

	always_comb begin
		ovf = 1'b0;
		case (op)
			ALU_ADD: begin
				ovf    = add_ovf;
				result = add_ovf ? (a[`DATA_W-1] ? max_neg : max_pos) : sum;
			end
			ALU_SUB: begin
				ovf    = sub_ovf;
				result = sub_ovf ? (a[`DATA_W-1] ? max_neg : max_pos) : diff;
			end
			ALU_XOR: result = a ^ b;
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_SLL: result = a << shamt;
			ALU_SRA: result = $signed(a) >>> shamt;
			ALU_ROR: result = rot[`DATA_W-1:0];
			default: result = '0;
		endcase
	end

	// each flag only moves when its enable is set
	always_ff @(posedge clk) begin
		if (reset) begin
			flags <= 3'b000;
		end else begin
			if (flag_write_en[`FLAG_Z]) begin
				flags[`FLAG_Z] <= (result == '0);
			end
			if (flag_write_en[`FLAG_V]) begin
				flags[`FLAG_V] <= ovf;
			end
			// N follows the saturated value
			if (flag_write_en[`FLAG_N]) begin
				flags[`FLAG_N] <= result[`DATA_W-1];
			end
		end
	end

endmodule

`default_nettype wire

// File: word_memory.sv
`include "cpu_defs.svh"
`timescale 1ns/10ps
`default_nettype none

module word_memory #(
	parameter int ADDR_W = 8
) (
	input  logic                clk,
	input  logic                write_en,
	input  logic [ADDR_W-1:0]   addr,
	input  logic [`DATA_W-1:0]  write_data,
	output logic [`DATA_W-1:0]  read_data
);

	localparam int DEPTH = 1 << ADDR_W;

	logic [`DATA_W-1:0] mem [0:DEPTH-1];

	// power-up contents, unwritten words load as zero
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (write_en) begin
			mem[addr] <= write_data;
		end
	end

	// combinational read, same cycle as the address
	assign read_data = mem[addr];

endmodule

`default_nettype wire

// File: cpu.sv
`include "cpu_defs.svh"
`timescale 1ns/10ps
`default_nettype none

module cpu (
	input  logic                clk,
	input  logic                reset,
	input  logic                imem_we,
	input  logic [`IMEM_AW-1:0] imem_addr,
	input  logic [`DATA_W-1:0]  imem_wdata,
	output logic                hlt,
	output logic [`DATA_W-1:0]  pc,
	output logic                retire_en,
	output logic [`REG_AW-1:0]  retire_reg,
	output logic [`DATA_W-1:0]  retire_data
);
	import isa_pkg::*;
	import core_pkg::*;

	logic [`DATA_W-1:0]  instruction;
	instr_t              instr;
	logic [`IMEM_AW-1:0] imem_idx;
	logic [`DATA_W-1:0]  pc_plus2;
	logic                halted;
	logic [2:0]          flags;
	alu_op_t             alu_op;
	logic                alu_imm;
	logic                src1_is_dst;
	logic                reg_write;
	logic                mem_write;
	logic [2:0]          flag_write_en;
	wb_src_t             wb_src;
	logic                branch;
	logic                halt_req;
	logic [`REG_AW-1:0]  src1_idx;
	logic [`DATA_W-1:0]  src1_data;
	logic [`DATA_W-1:0]  src2_data;
	logic [`DATA_W-1:0]  imm_ext;
	logic [`DATA_W-1:0]  alu_b;
	logic [`DATA_W-1:0]  alu_result;
	logic [`DATA_W-1:0]  mem_addr;
	logic [`DATA_W-1:0]  load_data;
	logic [7:0]          imm8;
	logic [`DATA_W-1:0]  byte_data;
	logic [`DATA_W-1:0]  write_data;

	pc_unit u_pc (
		.clk(clk), .reset(reset), .branch(branch),
		.cond(cond_t'(instruction[11:9])), .offset(instruction[8:0]),
		.flags(flags), .halt_req(halt_req),
		.pc(pc), .pc_plus2(pc_plus2), .halted(halted)
	);

	// loader owns the instruction memory port while it writes
	assign imem_idx = imem_we ? imem_addr : pc[`IMEM_AW:1];

	word_memory #(.ADDR_W(`IMEM_AW)) imem (
		.clk(clk), .write_en(imem_we), .addr(imem_idx),
		.write_data(imem_wdata), .read_data(instruction)
	);

	assign instr = instruction;

	control_unit u_ctrl (
		.reset(reset), .halted(halted), .opcode(instr.opcode),
		.alu_op(alu_op), .alu_imm(alu_imm), .src1_is_dst(src1_is_dst),
		.reg_write(reg_write), .mem_write(mem_write),
		.flag_write_en(flag_write_en), .wb_src(wb_src),
		.branch(branch), .halt_req(halt_req)
	);

	// byte loads read the old destination through port 1
	assign src1_idx = src1_is_dst ? instr.rd : instr.rs;

	register_file u_rf (
		.clk(clk), .reset(reset), .src1(src1_idx), .src2(instr.rt),
		.dst(instr.rd), .write_en(reg_write), .write_data(write_data),
		.src1_data(src1_data), .src2_data(src2_data)
	);

	// 4-bit immediate sits in the source-2 field
	assign imm_ext = {{(`DATA_W-4){instr.rt[3]}}, instr.rt};
	assign alu_b   = alu_imm ? imm_ext : src2_data;

	alu u_alu (
		.clk(clk), .reset(reset), .op(alu_op), .a(src1_data), .b(alu_b),
		.flag_write_en(flag_write_en), .result(alu_result), .flags(flags)
	);

	// plain wrapping add, the offset counts words
	assign mem_addr = src1_data + {imm_ext[`DATA_W-2:0], 1'b0};

	word_memory #(.ADDR_W(`DMEM_AW)) dmem (
		.clk(clk), .write_en(mem_write), .addr(mem_addr[`DMEM_AW:1]),
		.write_data(src2_data), .read_data(load_data)
	);

	// LHB fills the upper byte, LLB the lower
	assign imm8      = instruction[7:0];
	assign byte_data = (instr.opcode == LHB) ? {imm8, src1_data[7:0]}
	                                         : {src1_data[15:8], imm8};

	always_comb begin
		case (wb_src)
			WB_MEM:  write_data = load_data;
			WB_BYTE: write_data = byte_data;
			WB_PCS:  write_data = pc_plus2;
			default: write_data = alu_result;
		endcase
	end

	assign hlt = halted;

	// retire trace mirrors the register-file write
	assign retire_en   = reg_write;
	assign retire_reg  = instr.rd;
	assign retire_data = write_data;

endmodule

`default_nettype wire

// File: tb_cpu.sv
`include "cpu_defs.svh"
`timescale 1ns/10ps
`default_nettype none

module tb_cpu;
	import isa_pkg::*;
	import core_pkg::*;

	// per-test bounds that size the watchdog limit
	localparam int NUM_TESTS    = 6;
	localparam int RESET_CYCLES = 8;
	localparam int LOAD_CYCLES  = 64;
	localparam int RUN_CYCLES   = 64;
	localparam int HALT_CYCLES  = 10;
	// twice the longest possible run
	localparam int MAX_CYCLES   = 2 * NUM_TESTS *
		(RESET_CYCLES + LOAD_CYCLES + RUN_CYCLES + HALT_CYCLES);

	logic                clk;
	logic                reset;
	logic                imem_we;
	logic [`IMEM_AW-1:0] imem_addr;
	logic [`DATA_W-1:0]  imem_wdata;
	logic                hlt;
	logic [`DATA_W-1:0]  pc;
	logic                retire_en;
	logic [`REG_AW-1:0]  retire_reg;
	logic [`DATA_W-1:0]  retire_data;

	int    errors;
	int    checks;
	int    cycles;
	int    seed;
	string test_name;

	// program image of the running test
	logic [`DATA_W-1:0] prog [$];
	// ISA model state
	logic [`DATA_W-1:0] model_regs [0:(1<<`REG_AW)-1];
	logic [`DATA_W-1:0] model_mem [0:(1<<`DMEM_AW)-1];
	logic [`DATA_W-1:0] model_pc;
	logic               model_halted;
	logic               flag_z;
	logic               flag_v;
	logic               flag_n;

	cpu UUT (
		.clk(clk), .reset(reset), .imem_we(imem_we), .imem_addr(imem_addr),
		.imem_wdata(imem_wdata), .hlt(hlt), .pc(pc), .retire_en(retire_en),
		.retire_reg(retire_reg), .retire_data(retire_data)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic check_word(input string what, input logic [`DATA_W-1:0] expected,
		input logic [`DATA_W-1:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("** Error %s: %s expected %h actual %h", test_name, what, expected, actual);
		end
	endtask

	task automatic check_reg(input string what, input logic [`REG_AW-1:0] expected,
		input logic [`REG_AW-1:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("** Error %s: %s expected %h actual %h", test_name, what, expected, actual);
		end
	endtask

	task automatic check_pc(input string what, input logic [`DATA_W-1:0] expected,
		input logic [`DATA_W-1:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("** Error %s: %s expected %h actual %h", test_name, what, expected, actual);
		end
	endtask

	task automatic check_halt(input string what, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("** Error %s: %s expected %b actual %b", test_name, what, expected, actual);
		end
	endtask

	task automatic check_bit(input string what, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("** Error %s: %s expected %b actual %b", test_name, what, expected, actual);
		end
	endtask

	function automatic logic [`DATA_W-1:0] rand_word();
		logic [31:0] r;
		r = $random(seed);
		return r[`DATA_W-1:0];
	endfunction

	function automatic logic [`DATA_W-1:0] enc_reg(input opcode_t op, input logic [3:0] rd,
		input logic [3:0] rs, input logic [3:0] rt);
		return {op, rd, rs, rt};
	endfunction

	function automatic logic [`DATA_W-1:0] enc_byte(input opcode_t op, input logic [3:0] rd,
		input logic [7:0] imm);
		return {op, rd, imm};
	endfunction

	function automatic logic [`DATA_W-1:0] enc_branch(input cond_t c, input logic [8:0] off);
		return {B, c, off};
	endfunction

	// two byte loads build any 16-bit constant
	task automatic load_const(input logic [3:0] rd, input logic [`DATA_W-1:0] value);
		prog.push_back(enc_byte(LLB, rd, value[7:0]));
		prog.push_back(enc_byte(LHB, rd, value[15:8]));
	endtask

	function automatic logic cond_holds(input cond_t c);
		case (c)
			NE:      return !flag_z;
			EQ:      return flag_z;
			GT:      return !flag_z && !flag_n;
			LT:      return flag_n;
			GE:      return !flag_n;
			LE:      return flag_z || flag_n;
			OV:      return flag_v;
			default: return 1'b1;
		endcase
	endfunction

	function automatic logic [`DATA_W-1:0] alu_model(input alu_op_t op,
		input logic [`DATA_W-1:0] a, input logic [`DATA_W-1:0] b, output logic ovf);
		int s;
		ovf = 1'b0;
		case (op)
			ALU_ADD, ALU_SUB: begin
				if (op == ALU_ADD) begin
					s = int'($signed(a)) + int'($signed(b));
				end else begin
					s = int'($signed(a)) - int'($signed(b));
				end
				// clamp into the signed 16-bit range
				ovf = (s > 32767) || (s < -32768);
				if (s > 32767) begin
					s = 32767;
				end else if (s < -32768) begin
					s = -32768;
				end
				return s[`DATA_W-1:0];
			end
			ALU_XOR: return a ^ b;
			ALU_AND: return a & b;
			ALU_OR:  return a | b;
			ALU_SLL: return a << b[3:0];
			ALU_SRA: return $signed(a) >>> b[3:0];
			default: return (a >> b[3:0]) | (a << (5'd16 - {1'b0, b[3:0]}));
		endcase
	endfunction

	// executes the instruction at model_pc and returns the expected retire
	task automatic step_model(output logic en, output logic [`REG_AW-1:0] rd,
		output logic [`DATA_W-1:0] data);
		logic [`DATA_W-1:0] iw;
		opcode_t            op;
		logic [`DATA_W-1:0] a;
		logic [`DATA_W-1:0] b;
		logic [`DATA_W-1:0] simm;
		logic [`DATA_W-1:0] addr;
		logic [`DATA_W-1:0] res;
		logic [`DATA_W-1:0] next_pc;
		logic               ovf;
		wb_src_t            wb;
		iw      = prog[model_pc[`DATA_W-1:1]];
		op      = opcode_t'(iw[15:12]);
		rd      = iw[11:8];
		a       = model_regs[iw[7:4]];
		b       = model_regs[iw[3:0]];
		simm    = {{(`DATA_W-4){iw[3]}}, iw[3:0]};
		// the offset counts words so the immediate is doubled
		addr    = a + {simm[`DATA_W-2:0], 1'b0};
		next_pc = model_pc + 16'd2;
		res     = '0;
		wb      = WB_ALU;
		en      = 1'b1;
		case (op)
			ADD, SUB: begin
				res    = alu_model((op == ADD) ? ALU_ADD : ALU_SUB, a, b, ovf);
				flag_z = (res == '0);
				flag_v = ovf;
				flag_n = res[`DATA_W-1];
			end
			XOR, AND, OR: begin
				res    = alu_model((op == XOR) ? ALU_XOR : (op == AND) ? ALU_AND : ALU_OR,
				                   a, b, ovf);
				flag_z = (res == '0);
			end
			// shift amount is the unsigned immediate
			SLL, SRA, ROR: begin
				res    = alu_model((op == SLL) ? ALU_SLL : (op == SRA) ? ALU_SRA : ALU_ROR,
				                   a, {12'h000, iw[3:0]}, ovf);
				flag_z = (res == '0);
			end
			LW:       wb = WB_MEM;
			SW: begin
				en = 1'b0;
				model_mem[addr[`DMEM_AW:1]] = b;
			end
			LLB, LHB: wb = WB_BYTE;
			B: begin
				en = 1'b0;
				if (cond_holds(cond_t'(iw[11:9]))) begin
					next_pc = next_pc + {{(`DATA_W-10){iw[8]}}, iw[8:0], 1'b0};
				end
			end
			PCS:      wb = WB_PCS;
			HLT: begin
				en           = 1'b0;
				model_halted = 1'b1;
				next_pc      = model_pc;
			end
			default:  en = 1'b0;
		endcase
		case (wb)
			WB_MEM:  data = model_mem[addr[`DMEM_AW:1]];
			WB_BYTE: data = (op == LHB) ? {iw[7:0], model_regs[rd][7:0]}
			                            : {model_regs[rd][15:8], iw[7:0]};
			WB_PCS:  data = model_pc + 16'd2;
			default: data = res;
		endcase
		if (en) begin
			model_regs[rd] = data;
		end
		model_pc = next_pc;
	endtask

	// reset, load prog, then follow the model until HLT plus ten idle cycles
	task automatic run_program();
		logic               en;
		logic [`REG_AW-1:0] rd;
		logic [`DATA_W-1:0] data;
		int                 idle;
		@(posedge clk);
		reset <= 1'b1;
		repeat (RESET_CYCLES) begin
			@(negedge clk);
			check_bit("retire_en in reset", 1'b0, retire_en);
			@(posedge clk);
		end
		// loader writes land while reset is still high
		foreach (prog[i]) begin
			imem_we    <= 1'b1;
			imem_addr  <= `IMEM_AW'(i);
			imem_wdata <= prog[i];
			@(posedge clk);
		end
		imem_we <= 1'b0;
		reset   <= 1'b0;
		foreach (model_regs[i]) begin
			model_regs[i] = '0;
		end
		flag_z       = 1'b0;
		flag_v       = 1'b0;
		flag_n       = 1'b0;
		model_pc     = `RESET_PC;
		model_halted = 1'b0;
		idle         = 0;
		while (idle < HALT_CYCLES) begin
			@(negedge clk);
			check_halt("hlt", model_halted, hlt);
			check_pc("pc", model_pc, pc);
			if (model_halted) begin
				check_bit("retire_en after HLT", 1'b0, retire_en);
				idle++;
			end else if (int'(model_pc[`DATA_W-1:1]) >= prog.size()) begin
				errors++;
				$display("%s: model fetch at pc %h runs past the end of the program",
				         test_name, model_pc);
				model_halted = 1'b1;
			end else begin
				step_model(en, rd, data);
				check_bit("retire_en", en, retire_en);
				if (en) begin
					check_reg("retire_reg", rd, retire_reg);
					check_word("retire_data", data, retire_data);
				end
			end
		end
	endtask

	task automatic test_alu_ops();
		test_name = "alu_ops";
		prog.delete();
		load_const(4'd1, rand_word());
		load_const(4'd2, rand_word());
		prog.push_back(enc_reg(ADD, 4'd5, 4'd1, 4'd2));
		prog.push_back(enc_reg(SUB, 4'd6, 4'd1, 4'd2));
		prog.push_back(enc_reg(XOR, 4'd7, 4'd1, 4'd2));
		prog.push_back(enc_reg(AND, 4'd8, 4'd1, 4'd2));
		prog.push_back(enc_reg(OR, 4'd9, 4'd1, 4'd2));
		// large operands push both sums past the signed limits
		load_const(4'd3, 16'h7000);
		load_const(4'd4, 16'h9000);
		prog.push_back(enc_reg(ADD, 4'd10, 4'd3, 4'd3));
		prog.push_back(enc_reg(ADD, 4'd11, 4'd4, 4'd4));
		prog.push_back(enc_reg(SUB, 4'd12, 4'd3, 4'd4));
		prog.push_back(enc_reg(SUB, 4'd13, 4'd4, 4'd3));
		prog.push_back(enc_reg(HLT, 4'd0, 4'd0, 4'd0));
		run_program();
	endtask

	task automatic test_shifts();
		test_name = "shifts";
		prog.delete();
		load_const(4'd1, rand_word());
		// negative operand for the sign fill of SRA
		load_const(4'd2, rand_word() | 16'h8000);
		prog.push_back(enc_reg(SLL, 4'd3, 4'd1, 4'(rand_word())));
		prog.push_back(enc_reg(SRA, 4'd4, 4'd1, 4'(rand_word())));
		prog.push_back(enc_reg(ROR, 4'd5, 4'd1, 4'(rand_word())));
		prog.push_back(enc_reg(SRA, 4'd6, 4'd2, 4'(rand_word())));
		prog.push_back(enc_reg(ROR, 4'd7, 4'd2, 4'(rand_word())));
		prog.push_back(enc_reg(ROR, 4'd8, 4'd2, 4'd0));
		prog.push_back(enc_reg(HLT, 4'd0, 4'd0, 4'd0));
		run_program();
	endtask

	task automatic test_byte_loads();
		test_name = "byte_loads";
		prog.delete();
		load_const(4'd1, rand_word());
		prog.push_back(enc_byte(LHB, 4'd2, 8'(rand_word())));
		prog.push_back(enc_byte(LLB, 4'd2, 8'(rand_word())));
		// low byte replaced, high byte kept
		prog.push_back(enc_byte(LLB, 4'd1, 8'(rand_word())));
		prog.push_back(enc_byte(LHB, 4'd3, 8'(rand_word())));
		prog.push_back(enc_reg(HLT, 4'd0, 4'd0, 4'd0));
		run_program();
	endtask

	task automatic test_load_store();
		test_name = "load_store";
		prog.delete();
		prog.push_back(enc_byte(LLB, 4'd1, 8'h80 | (8'(rand_word()) & 8'h3E)));
		load_const(4'd2, rand_word());
		load_const(4'd3, rand_word());
		load_const(4'd5, rand_word());
		load_const(4'd12, rand_word());
		// the source-2 field is both the stored register and the offset
		prog.push_back(enc_reg(SW, 4'd0, 4'd1, 4'd2));
		prog.push_back(enc_reg(SW, 4'd0, 4'd1, 4'd3));
		prog.push_back(enc_reg(SW, 4'd0, 4'd1, 4'd5));
		prog.push_back(enc_reg(SW, 4'd0, 4'd1, 4'hC));
		prog.push_back(enc_reg(LW, 4'd6, 4'd1, 4'd2));
		prog.push_back(enc_reg(LW, 4'd7, 4'd1, 4'd3));
		prog.push_back(enc_reg(LW, 4'd8, 4'd1, 4'd5));
		prog.push_back(enc_reg(LW, 4'd9, 4'd1, 4'hC));
		// base minus 16 bytes was never written
		prog.push_back(enc_reg(LW, 4'd10, 4'd1, 4'h8));
		prog.push_back(enc_reg(HLT, 4'd0, 4'd0, 4'd0));
		run_program();
	endtask

	task automatic test_branches();
		test_name = "branches";
		prog.delete();
		load_const(4'd1, rand_word());
		load_const(4'd2, rand_word());
		load_const(4'd5, 16'h7000);
		load_const(4'd6, 16'h9000);
		// first pass flags take every condition, second pass flags fall through
		for (int i = 0; i < 16; i++) begin
			case (i)
				// zero result sets Z only
				1, 4, 5, 8, 10, 11, 14:
					prog.push_back(enc_reg(SUB, 4'd3, 4'd1, 4'd1));
				// positive saturation sets V only
				0, 2, 6, 9, 13:
					prog.push_back(enc_reg(ADD, 4'd3, 4'd5, 4'd5));
				// negative saturation sets V and N
				3, 12:
					prog.push_back(enc_reg(ADD, 4'd3, 4'd6, 4'd6));
				default:
					prog.push_back(enc_reg(SUB, 4'd3, 4'd1, 4'd2));
			endcase
			// a taken branch skips the marker load
			prog.push_back(enc_branch(cond_t'(i[2:0]), 9'd1));
			prog.push_back(enc_byte(LLB, 4'd15, 8'(i)));
		end
		prog.push_back(enc_reg(HLT, 4'd0, 4'd0, 4'd0));
		run_program();
	endtask

	task automatic test_pcs_halt();
		test_name = "pcs_halt";
		prog.delete();
		prog.push_back(enc_reg(NOP, 4'd0, 4'd0, 4'd0));
		prog.push_back(enc_reg(PCS, 4'd1, 4'd0, 4'd0));
		prog.push_back(enc_reg(NOP, 4'd0, 4'd0, 4'd0));
		prog.push_back(enc_reg(PCS, 4'd2, 4'd0, 4'd0));
		prog.push_back(enc_reg(HLT, 4'd0, 4'd0, 4'd0));
		// never reached once the core halts
		prog.push_back(enc_reg(PCS, 4'd3, 4'd0, 4'd0));
		run_program();
	endtask

	// watchdog on total run length
	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles in test %s, checks %0d, errors %0d",
		         cycles, test_name, checks, errors);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		reset      = 1'b1;
		imem_we    = 1'b0;
		imem_addr  = '0;
		imem_wdata = '0;
		errors     = 0;
		checks     = 0;
		seed       = 82837;
		test_name  = "init";
		// data memory starts cleared and keeps its contents between tests
		foreach (model_mem[i]) begin
			model_mem[i] = '0;
		end
		test_alu_ops();
		test_shifts();
		test_byte_loads();
		test_load_store();
		test_branches();
		test_pcs_halt();
		$display("checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+.
isa_pkg.sv
core_pkg.sv
pc_unit.sv
control_unit.sv
register_file.sv
alu.sv
word_memory.sv
cpu.sv
tb_cpu.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps --top-module tb_cpu \
	-Mdir obj_dir -f compile.f
if [ $? -ne 0 ]; then
	echo "Verilator build did not complete"
	exit 1
fi

./obj_dir/Vtb_cpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Testbench failed" sim.log; then
	exit 1
fi
exit 0
